//--- rtl/socPkg.sv
package socPkg;

    localparam int BUS_ADDR_WIDTH   = 32;
    localparam int BUS_DATA_WIDTH   = 32;
    localparam int BYTE_LANES       = BUS_DATA_WIDTH / 8;
    localparam int RAM_ADDR_WIDTH   = 10;
    localparam int RAM_WORDS        = 1 << RAM_ADDR_WIDTH;
    localparam int TIMER_ADDR_WIDTH = 3;
    localparam int TIMER_CHANNELS   = 3;
    localparam int IO_WIDTH         = 8;
    localparam int IRQ_COUNT        = 4;
    localparam int IRQ_IO_LINE      = 3;    // lines 0..2 belong to the timers

    typedef logic [BUS_ADDR_WIDTH-1:0]      busAddrT;
    typedef logic [BUS_DATA_WIDTH-1:0]      busDataT;
    typedef logic [BYTE_LANES-1:0]          byteEnT;
    typedef logic [RAM_ADDR_WIDTH-1:0]      ramAddrT;
    typedef logic [TIMER_ADDR_WIDTH-1:0]    timerAddrT;
    typedef logic [$clog2(IRQ_COUNT+1)-1:0] irqVecT;

    // address bits 31..28
    localparam logic [3:0] RAM_REGION   = 4'd0;
    localparam logic [3:0] TIMER_REGION = 4'd1;
    localparam logic [3:0] IO_REGION    = 4'd2;

    localparam timerAddrT TIMER_CONTROL    = 3'd3;
    localparam timerAddrT TIMER_COUNT_BASE = 3'd4;   // counts at 4..6, read only

    localparam logic IO_LATCH = 1'b0;
    localparam logic IO_INPUT = 1'b1;

endpackage

//--- rtl/busInterconnect.sv
`timescale 1ns/1ps

module busInterconnect
    import socPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  busAddrT   address,
    input  logic      read,
    input  logic      write,
    output logic      readValid,
    output busDataT   dataOut,

    output logic      ramRead,
    output logic      ramWrite,
    output ramAddrT   ramAddress,
    input  logic      ramValid,
    input  busDataT   ramData,

    output logic      timerRead,
    output logic      timerWrite,
    output timerAddrT timerAddress,
    input  logic      timerValid,
    input  busDataT   timerData,

    output logic      ioRead,
    output logic      ioWrite,
    output logic      ioAddress,
    input  logic      ioValid,
    input  busDataT   ioData
);

    logic [3:0] region;
    logic       ramSel;
    logic       timerSel;
    logic       ioSel;
    logic       unmappedValid;  // answers reads nobody owns

    assign region   = address[31:28];
    assign ramSel   = (region == RAM_REGION);
    assign timerSel = (region == TIMER_REGION);
    assign ioSel    = (region == IO_REGION);

    // word addresses, byte offset dropped
    assign ramAddress   = address[RAM_ADDR_WIDTH+1:2];
    assign timerAddress = address[TIMER_ADDR_WIDTH+1:2];
    assign ioAddress    = address[2];

    assign ramRead    = read && ramSel;
    assign ramWrite   = write && ramSel;
    assign timerRead  = read && timerSel;
    assign timerWrite = write && timerSel;
    assign ioRead     = read && ioSel;
    assign ioWrite    = write && ioSel;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            unmappedValid <= 1'b0;
        end else begin
            unmappedValid <= read && !(ramSel || timerSel || ioSel);
        end
    end

    assign readValid = ramValid || timerValid || ioValid || unmappedValid;

    // at most one slave answers per cycle
    always_comb begin
        dataOut = '0;   // also the unmapped answer
        if (ramValid) begin
            dataOut = ramData;
        end else if (timerValid) begin
            dataOut = timerData;
        end else if (ioValid) begin
            dataOut = ioData;
        end
    end

endmodule

//--- rtl/ram.sv
`timescale 1ns/1ps

module ram
    import socPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    read,
    input  logic    write,
    input  byteEnT  bwe,
    input  ramAddrT address,
    input  busDataT dataIn,
    output logic    readValid,
    output busDataT dataOut
);

    busDataT memory [RAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (write) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (bwe[lane]) begin
                    memory[address][lane*8 +: 8] <= dataIn[lane*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            dataOut <= memory[address];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= read;  // one cycle after the strobe
        end
    end

endmodule

//--- rtl/timer.sv
`timescale 1ns/1ps

module timer
    import socPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      read,
    input  logic                      write,
    input  timerAddrT                 address,
    input  busDataT                   dataIn,
    output logic                      readValid,
    output busDataT                   dataOut,
    output logic [TIMER_CHANNELS-1:0] irq
);

    busDataT                   reloadValue [TIMER_CHANNELS];
    busDataT                   count [TIMER_CHANNELS];
    logic [TIMER_CHANNELS-1:0] enable;     // control register bits

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enable <= '0;
            irq    <= '0;
            for (int ch = 0; ch < TIMER_CHANNELS; ch++) begin
                reloadValue[ch] <= '0;
                count[ch]       <= '0;
            end
        end else begin
            if (write && address == TIMER_CONTROL) begin
                enable <= dataIn[TIMER_CHANNELS-1:0];
            end
            for (int ch = 0; ch < TIMER_CHANNELS; ch++) begin
                irq[ch] <= 1'b0;
                if (write && address == timerAddrT'(ch)) begin
                    // a new reload value restarts the count too
                    reloadValue[ch] <= dataIn;
                    count[ch]       <= dataIn;
                end else if (enable[ch]) begin
                    if (count[ch] == '0) begin
                        count[ch] <= reloadValue[ch];
                        irq[ch]   <= 1'b1;  // one pulse per wrap
                    end else begin
                        count[ch] <= count[ch] - 1'b1;
                    end
                end
            end
        end
    end

    // read mux, offset 7 reads zero
    always_ff @(posedge clk) begin
        if (read) begin
            dataOut <= '0;
            if (address == TIMER_CONTROL) begin
                dataOut <= BUS_DATA_WIDTH'(enable);
            end
            for (int ch = 0; ch < TIMER_CHANNELS; ch++) begin
                if (address == timerAddrT'(ch)) begin
                    dataOut <= reloadValue[ch];
                end
                if (address == TIMER_COUNT_BASE + timerAddrT'(ch)) begin
                    dataOut <= count[ch];   // live value
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= read;
        end
    end

endmodule

//--- rtl/io.sv
`timescale 1ns/1ps

module io
    import socPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                read,
    input  logic                write,
    input  logic                address,
    input  busDataT             dataIn,
    input  logic [IO_WIDTH-1:0] ioIn,
    output logic                readValid,
    output busDataT             dataOut,
    output logic [IO_WIDTH-1:0] ioOut,
    output logic                ioIrq
);

    logic [IO_WIDTH-1:0] inSample;
    logic [IO_WIDTH-1:0] inPrevious;   // for edge detection

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ioOut      <= '0;
            inSample   <= '0;
            inPrevious <= '0;
            ioIrq      <= 1'b0;
            readValid  <= 1'b0;
        end else begin
            if (write && address == IO_LATCH) begin
                ioOut <= dataIn[IO_WIDTH-1:0];
            end
            inSample   <= ioIn;
            inPrevious <= inSample;
            ioIrq      <= |(inSample & ~inPrevious);  // any rising bit
            readValid  <= read;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            dataOut <= (address == IO_INPUT) ? BUS_DATA_WIDTH'(inSample)
                                             : BUS_DATA_WIDTH'(ioOut);
        end
    end

endmodule

//--- rtl/interruptController.sv
`timescale 1ns/1ps

module interruptController
    import socPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [IRQ_COUNT-1:0] triggerInterrupt,
    input  logic                 interruptAcknowledge,
    input  irqVecT               interruptIn,
    output logic                 interruptRequest,
    output irqVecT               interruptOut
);

    logic [IRQ_COUNT-1:0] pending;
    logic [IRQ_COUNT-1:0] pendingNext;
    logic [IRQ_COUNT-1:0] ackMask;
    irqVecT               lowestPending;

    always_comb begin
        ackMask = '0;
        for (int line = 0; line < IRQ_COUNT; line++) begin
            if (interruptAcknowledge && interruptIn == irqVecT'(line)) begin
                ackMask[line] = 1'b1;
            end
        end
    end

    // a trigger in the ack cycle keeps the line pending
    assign pendingNext = (pending & ~ackMask) | triggerInterrupt;

    // scan downwards so the lowest number wins
    always_comb begin
        lowestPending = '0;
        for (int line = IRQ_COUNT - 1; line >= 0; line--) begin
            if (pendingNext[line]) begin
                lowestPending = irqVecT'(line);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending          <= '0;
            interruptRequest <= 1'b0;
            interruptOut     <= '0;
        end else begin
            pending          <= pendingNext;
            interruptRequest <= |pendingNext;
            interruptOut     <= lowestPending;
        end
    end

endmodule

//--- rtl/peripheralSoc.sv
`timescale 1ns/1ps

module peripheralSoc
    import socPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  busAddrT             address,
    input  logic                read,
    input  logic                write,
    input  byteEnT              bwe,
    input  busDataT             dataIn,
    output logic                readValid,
    output busDataT             dataOut,
    input  logic [IO_WIDTH-1:0] ioIn,
    output logic [IO_WIDTH-1:0] ioOut,
    input  logic                interruptAcknowledge,
    input  irqVecT              interruptIn,
    output logic                interruptRequest,
    output irqVecT              interruptOut
);

    // slave side of the interconnect
    logic                      ramRead;
    logic                      ramWrite;
    ramAddrT                   ramAddress;
    logic                      ramValid;
    busDataT                   ramData;

    logic                      timerRead;
    logic                      timerWrite;
    timerAddrT                 timerAddress;
    logic                      timerValid;
    busDataT                   timerData;

    logic                      ioRead;
    logic                      ioWrite;
    logic                      ioAddress;
    logic                      ioValid;
    busDataT                   ioData;

    // interrupt sources
    logic [TIMER_CHANNELS-1:0] timerIrq;
    logic                      ioIrq;
    logic [IRQ_COUNT-1:0]      triggerInterrupt;

    assign triggerInterrupt[TIMER_CHANNELS-1:0] = timerIrq;  // lines 0..2
    assign triggerInterrupt[IRQ_IO_LINE]        = ioIrq;

    busInterconnect
    busInterconnect(
        .clk,
        .rstN,
        .address,
        .read,
        .write,
        .readValid,
        .dataOut,
        .ramRead,
        .ramWrite,
        .ramAddress,
        .timerRead,
        .timerWrite,
        .timerAddress,
        .ioRead,
        .ioWrite,
        .ioAddress,
        .ramValid,
        .ramData,
        .timerValid,
        .timerData,
        .ioValid,
        .ioData
    );

    ram
    ram(
        .clk,
        .rstN,
        .read                   (ramRead),
        .write                  (ramWrite),
        .bwe,
        .address                (ramAddress),
        .dataIn,
        .readValid              (ramValid),
        .dataOut                (ramData)
    );

    timer
    timer(
        .clk,
        .rstN,
        .read                   (timerRead),
        .write                  (timerWrite),
        .address                (timerAddress),
        .dataIn,
        .readValid              (timerValid),
        .dataOut                (timerData),
        .irq                    (timerIrq)
    );

    io
    io(
        .clk,
        .rstN,
        .read                   (ioRead),
        .write                  (ioWrite),
        .address                (ioAddress),
        .dataIn,
        .ioIn,
        .readValid              (ioValid),
        .dataOut                (ioData),
        .ioOut,
        .ioIrq
    );

    interruptController
    interruptController(
        .clk,
        .rstN,
        .triggerInterrupt,
        .interruptAcknowledge,
        .interruptIn,
        .interruptRequest,
        .interruptOut
    );

endmodule

//--- tests/socTb.sv
`timescale 1ns/1ps

module socTb
    import socPkg::*;
();

    localparam int CLOCK_PERIOD    = 20;
    localparam int RAM_TEST_WORDS  = 16;
    localparam int READ_TIMEOUT    = 4;
    localparam int WATCHDOG_CYCLES = 20000;  // tests need well under a thousand cycles

    logic                clk;
    logic                rstN;
    busAddrT             address;
    logic                read;
    logic                write;
    byteEnT              bwe;
    busDataT             dataIn;
    logic                readValid;
    busDataT             dataOut;
    logic [IO_WIDTH-1:0] ioIn;
    logic [IO_WIDTH-1:0] ioOut;
    logic                interruptAcknowledge;
    irqVecT              interruptIn;
    logic                interruptRequest;
    irqVecT              interruptOut;

    int      errorCount;
    int      testCount;
    int      failedTests;
    busDataT ramModel [RAM_WORDS];       // expected RAM contents
    ramAddrT usedWords [RAM_TEST_WORDS];

    peripheralSoc u_peripheralSoc(
        .clk,
        .rstN,
        .address,
        .read,
        .write,
        .bwe,
        .dataIn,
        .readValid,
        .dataOut,
        .ioIn,
        .ioOut,
        .interruptAcknowledge,
        .interruptIn,
        .interruptRequest,
        .interruptOut
    );

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    readLatency: assert property (@(posedge clk) disable iff (!rstN) read |=> readValid)
        else begin
            $display("readValid did not follow a read after one cycle");
            errorCount++;
        end

    noStrayValid: assert property (@(posedge clk) disable iff (!rstN) readValid |-> $past(read))
        else begin
            $display("readValid was raised without a read in the cycle before");
            errorCount++;
        end

    // a trigger always leaves the request high on the next edge
    requestAfterTrigger: assert property (@(posedge clk) disable iff (!rstN)
        (|u_peripheralSoc.triggerInterrupt) |=> interruptRequest)
        else begin
            $display("interruptRequest stayed low after an interrupt trigger");
            errorCount++;
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    function automatic busAddrT regionAddress(input logic [3:0] region, input int wordIndex);
        return (busAddrT'(region) << 28) | (busAddrT'(wordIndex) << 2);
    endfunction

    function automatic busDataT mergeBytes(input busDataT oldWord, input busDataT newWord,
                                           input byteEnT enables);
        busDataT merged;
        merged = oldWord;
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (enables[lane]) begin
                merged[lane*8 +: 8] = newWord[lane*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic writeWord(input busAddrT addr, input busDataT data, input byteEnT enables);
        @(posedge clk);
        address <= addr;
        write   <= 1'b1;
        bwe     <= enables;
        dataIn  <= data;
        @(posedge clk);
        write   <= 1'b0;
    endtask

    task automatic readWord(input busAddrT addr, output busDataT data);
        int waited;
        @(posedge clk);
        address <= addr;
        read    <= 1'b1;
        @(posedge clk);
        read    <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!readValid && waited < READ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!readValid) begin
            $display("read of address %h never returned readValid", addr);
            errorCount++;
        end
        data = dataOut;
    endtask

    task automatic acknowledge(input irqVecT line);
        @(posedge clk);
        interruptAcknowledge <= 1'b1;
        interruptIn          <= line;
        @(posedge clk);
        interruptAcknowledge <= 1'b0;
        @(negedge clk);  // pending bit already updated here
    endtask

    task automatic waitForRequest(input int limit, output bit seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!interruptRequest && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        seen = interruptRequest;
    endtask

    task automatic checkValue(input string name, input busDataT expected, input busDataT actual);
        assert (actual == expected)
        else begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkTrue(input bit condition, input string what);
        assert (condition)
        else begin
            $display("error: %s", what);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: passed", name);
        end else begin
            failedTests++;
            $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        busDataT             word;
        busDataT             previous;
        byteEnT              enables;
        int                  errorsBefore;
        int                  reloadCount;
        bit                  seen;
        logic [IO_WIDTH-1:0] pattern;
        logic [IO_WIDTH-1:0] latchValue;
        time                 enableTime;

        errorCount           = 0;
        testCount            = 0;
        failedTests          = 0;
        rstN                 = 1'b0;
        address              = '0;
        read                 = 1'b0;
        write                = 1'b0;
        bwe                  = '0;
        dataIn               = '0;
        ioIn                 = '0;
        interruptAcknowledge = 1'b0;
        interruptIn          = '0;
        word = $urandom(1);  // seed once
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // RAM byte enables
        errorsBefore = errorCount;
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            usedWords[i] = ramAddrT'($urandom % RAM_WORDS);
            word = $urandom;
            ramModel[usedWords[i]] = word;
            writeWord(regionAddress(RAM_REGION, int'(usedWords[i])), word, '1);
        end
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            enables = byteEnT'($urandom);
            word = $urandom;
            ramModel[usedWords[i]] = mergeBytes(ramModel[usedWords[i]], word, enables);
            writeWord(regionAddress(RAM_REGION, int'(usedWords[i])), word, enables);
        end
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            readWord(regionAddress(RAM_REGION, int'(usedWords[i])), word);
            checkValue("ram byte enables", ramModel[usedWords[i]], word);
        end
        finishTest("ram byte enables", errorsBefore);

        // parallel IO latch, input sampling and edge interrupt
        errorsBefore = errorCount;
        latchValue = IO_WIDTH'($urandom);
        writeWord(regionAddress(IO_REGION, 0), busDataT'(latchValue), '1);
        @(negedge clk);
        checkValue("io output latch", busDataT'(latchValue), busDataT'(ioOut));
        readWord(regionAddress(IO_REGION, 0), word);
        checkValue("io latch readback", busDataT'(latchValue), word);
        pattern = IO_WIDTH'($urandom) | 8'h01;  // at least one rising bit
        @(posedge clk);
        ioIn <= pattern;
        waitForRequest(8, seen);
        checkTrue(seen, "rising ioIn bit raised no interrupt request");
        checkValue("io edge interrupt number", busDataT'(IRQ_IO_LINE), busDataT'(interruptOut));
        readWord(regionAddress(IO_REGION, 1), word);
        checkValue("io input sample", busDataT'(pattern), word);
        acknowledge(irqVecT'(IRQ_IO_LINE));
        checkTrue(!interruptRequest, "request stayed high after acknowledging the io line");
        finishTest("io port", errorsBefore);

        // channel 1 counts down and reloads
        errorsBefore = errorCount;
        reloadCount = 12 + int'($urandom % 20);
        writeWord(regionAddress(TIMER_REGION, 1), busDataT'(reloadCount), '1);
        writeWord(regionAddress(TIMER_REGION, int'(TIMER_CONTROL)), 32'h2, '1);
        enableTime = $time;
        previous = busDataT'(reloadCount) + 1;
        for (int i = 0; i < 3; i++) begin
            readWord(regionAddress(TIMER_REGION, int'(TIMER_COUNT_BASE) + 1), word);
            checkTrue(word <= busDataT'(reloadCount), "timer count above its reload value");
            checkTrue(word < previous, "timer count did not decrease between reads");
            previous = word;
        end
        waitForRequest(reloadCount + 3, seen);
        checkTrue(seen, "timer channel 1 raised no interrupt request");
        checkTrue($time - enableTime <= time'((reloadCount + 3) * CLOCK_PERIOD),
                  "timer channel 1 interrupted later than its reload value plus three cycles");
        checkValue("timer interrupt number", 1, busDataT'(interruptOut));
        for (int repeatIndex = 0; repeatIndex < 2; repeatIndex++) begin
            acknowledge(irqVecT'(1));
            checkTrue(!interruptRequest, "request stayed high after acknowledging channel 1");
            waitForRequest(reloadCount + 3, seen);
            checkTrue(seen, "timer channel 1 did not interrupt again after reload");
            checkValue("timer repeat interrupt number", 1, busDataT'(interruptOut));
        end
        writeWord(regionAddress(TIMER_REGION, int'(TIMER_CONTROL)), 32'h0, '1);
        acknowledge(irqVecT'(1));
        checkTrue(!interruptRequest, "request stayed high after disabling channel 1");
        finishTest("timer counting", errorsBefore);

        // channels 0 and 2 fire in the same cycle
        errorsBefore = errorCount;
        writeWord(regionAddress(TIMER_REGION, 0), 32'd20, '1);
        writeWord(regionAddress(TIMER_REGION, 2), 32'd20, '1);
        writeWord(regionAddress(TIMER_REGION, int'(TIMER_CONTROL)), 32'h5, '1);
        waitForRequest(25, seen);
        checkTrue(seen, "timer channels 0 and 2 raised no interrupt request");
        checkValue("priority first line", 0, busDataT'(interruptOut));
        writeWord(regionAddress(TIMER_REGION, int'(TIMER_CONTROL)), 32'h0, '1);
        acknowledge(irqVecT'(0));
        checkTrue(interruptRequest, "request fell while line 2 was still pending");
        checkValue("priority second line", 2, busDataT'(interruptOut));
        acknowledge(irqVecT'(2));
        checkTrue(!interruptRequest, "request stayed high after the last acknowledge");
        finishTest("interrupt priority", errorsBefore);

        // regions 3 to 15 belong to no slave
        errorsBefore = errorCount;
        for (int region = 3; region < 16; region++) begin
            readWord(regionAddress(4'(region), int'($urandom % RAM_WORDS)), word);
            checkValue("unmapped read", '0, word);
            writeWord(regionAddress(4'(region), int'(usedWords[region % RAM_TEST_WORDS])),
                      $urandom, '1);
            writeWord(regionAddress(4'(region), 0), $urandom, '1);  // io latch, reload 0
            writeWord(regionAddress(4'(region), 3), $urandom, '1);  // timer control
        end
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            readWord(regionAddress(RAM_REGION, int'(usedWords[i])), word);
            checkValue("ram after unmapped writes", ramModel[usedWords[i]], word);
        end
        readWord(regionAddress(IO_REGION, 0), word);
        checkValue("io latch after unmapped writes", busDataT'(latchValue), word);
        checkValue("ioOut after unmapped writes", busDataT'(latchValue), busDataT'(ioOut));
        readWord(regionAddress(TIMER_REGION, 0), word);
        checkValue("reload 0 after unmapped writes", 32'd20, word);
        readWord(regionAddress(TIMER_REGION, 1), word);
        checkValue("reload 1 after unmapped writes", busDataT'(reloadCount), word);
        readWord(regionAddress(TIMER_REGION, 2), word);
        checkValue("reload 2 after unmapped writes", 32'd20, word);
        readWord(regionAddress(TIMER_REGION, int'(TIMER_CONTROL)), word);
        checkValue("control after unmapped writes", 32'h0, word);
        finishTest("unmapped region", errorsBefore);

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- flist.f
rtl/socPkg.sv
rtl/busInterconnect.sv
rtl/ram.sv
rtl/timer.sv
rtl/io.sv
rtl/interruptController.sv
rtl/peripheralSoc.sv
tests/socTb.sv

//--- run.sh
#!/bin/sh
# build and run the peripheral SoC testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module socTb -o socTb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/socTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0
